// File: common/adc_macros.svh
`ifndef ADC_MACROS_SVH
`define ADC_MACROS_SVH

// memory map geometry.
`define MEM_SIZE 32
`define WD_DATA_WIDTH 8
`define ADDR_WIDTH 5

// packet sizes in words.
`define SDC_SAMPLES 8
`define CHAN_SAMPLES 4

// sample-data block, samples then trigger.
`define SDC_BASE_ID 0
`define SDC_VALID_ID 8

// channel-mux block.
`define CHAN_MUX_BASE_ID 9
`define CHAN_MUX_VALID_ID 13

// single word, stored and triggered by the same write.
`define BUFF_CONFIG_ID 14

// addresses 15 and up are unused.

`endif

// File: common/adc_pkg.sv
package adc_pkg;

	// gatherer FSM.
	typedef enum logic {
		COLLECT, // filling the sample store.
		HOLD // packet presented, waiting for ready.
	} gather_state_t;

	// which store a memory-map write lands in.
	// trigger addresses fall under REGION_NONE.
	typedef enum logic [1:0] {
		REGION_SDC,
		REGION_CHAN,
		REGION_BUFF,
		REGION_NONE
	} region_t;

endpackage

// File: hw/mem_capture.sv
`timescale 1ns/10ps
`include "adc_macros.svh"

module mem_capture (
	input logic clk,
	input logic rst,
	input logic [`MEM_SIZE-1:0] fresh_bits,
	input logic [`MEM_SIZE-1:0][`WD_DATA_WIDTH-1:0] read_resps,
	output logic state_rdy,
	output logic wr_en,
	output logic [`ADDR_WIDTH-1:0] wr_addr,
	output logic [`WD_DATA_WIDTH-1:0] wr_data,
	output adc_pkg::region_t wr_region
);
	logic [`MEM_SIZE-1:0] pending; // words captured but not yet sent.
	logic [`MEM_SIZE-1:0][`WD_DATA_WIDTH-1:0] shadow;
	logic [`ADDR_WIDTH-1:0] next_addr;
	adc_pkg::region_t next_region;

	function automatic adc_pkg::region_t classify(input logic [`ADDR_WIDTH-1:0] addr);
		adc_pkg::region_t r;
		int a;
		a = int'(addr);
		r = adc_pkg::REGION_NONE;
		if (a >= `SDC_BASE_ID && a < `SDC_BASE_ID + `SDC_SAMPLES)
			r = adc_pkg::REGION_SDC;
		else if (a >= `CHAN_MUX_BASE_ID && a < `CHAN_MUX_BASE_ID + `CHAN_SAMPLES)
			r = adc_pkg::REGION_CHAN;
		else if (a == `BUFF_CONFIG_ID)
			r = adc_pkg::REGION_BUFF;
		return r;
	endfunction

	// lowest pending address wins.
	always_comb begin
		next_addr = '0;
		for (int i = `MEM_SIZE - 1; i >= 0; i--) begin
			if (pending[i])
				next_addr = `ADDR_WIDTH'(i);
		end
	end

	assign next_region = classify(next_addr);

	// idle once the last pulse has gone out.
	assign state_rdy = ~|pending && !wr_en;

	always_ff @(posedge clk) begin
		if (rst) begin
			pending <= '0;
			wr_en <= 1'b0;
		end else if (state_rdy) begin
			pending <= fresh_bits; // snapshot.
			wr_en <= 1'b0;
		end else if (|pending) begin
			pending[next_addr] <= 1'b0;
			wr_en <= 1'b1;
		end else begin
			wr_en <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (state_rdy) begin
			for (int i = 0; i < `MEM_SIZE; i++) begin
				if (fresh_bits[i])
					shadow[i] <= read_resps[i];
			end
		end
		if (|pending) begin
			wr_addr <= next_addr;
			wr_data <= shadow[next_addr];
			wr_region <= next_region;
		end
	end

	// next snapshot only after the last pulse of a burst.
	a_rdy_after_pulse: assert property (@(posedge clk) disable iff (rst)
		$rose(state_rdy) |-> $past(wr_en));

	a_drain_order: assert property (@(posedge clk) disable iff (rst)
		(wr_en && $past(wr_en)) |-> (wr_addr > $past(wr_addr)));

endmodule

// File: hw/packet_gather.sv
`timescale 1ns/10ps
`include "adc_macros.svh"

module packet_gather #(
	parameter int SAMPLES = 1,
	parameter int BASE_ID = 0,
	parameter int VALID_ID = 0,
	parameter adc_pkg::region_t REGION = adc_pkg::REGION_NONE
) (
	input logic clk,
	input logic rst,
	input logic wr_en,
	input logic [`ADDR_WIDTH-1:0] wr_addr,
	input logic [`WD_DATA_WIDTH-1:0] wr_data,
	input adc_pkg::region_t wr_region,
	output logic valid,
	output logic [SAMPLES-1:0][`WD_DATA_WIDTH-1:0] data,
	input logic ready
);
	localparam int IDX_W = (SAMPLES > 1) ? $clog2(SAMPLES) : 1;

	adc_pkg::gather_state_t state;
	logic [SAMPLES-1:0][`WD_DATA_WIDTH-1:0] store;
	logic [SAMPLES-1:0][`WD_DATA_WIDTH-1:0] store_next;
	logic [`ADDR_WIDTH-1:0] offset;
	logic store_hit;
	logic trig_hit;
	logic trig_pend; // trigger seen during HOLD.
	logic fire;
	logic xfer;

	assign offset = wr_addr - `ADDR_WIDTH'(BASE_ID);
	assign store_hit = wr_en && (wr_region == REGION);
	assign trig_hit = wr_en && (wr_addr == `ADDR_WIDTH'(VALID_ID));
	assign xfer = valid && ready;
	assign valid = (state == adc_pkg::HOLD);

	// launch on a fresh trigger or one left over from HOLD.
	assign fire = (state == adc_pkg::COLLECT) && (trig_hit || trig_pend);

	// merge the current write so a same-cycle trigger sees it.
	always_comb begin
		store_next = store;
		if (store_hit)
			store_next[offset[IDX_W-1:0]] = wr_data;
	end

	always_ff @(posedge clk) begin
		if (rst)
			store <= '0;
		else
			store <= store_next;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= adc_pkg::COLLECT;
			trig_pend <= 1'b0;
		end else begin
			case (state)
				adc_pkg::COLLECT: begin
					if (fire) begin
						state <= adc_pkg::HOLD;
						trig_pend <= 1'b0;
					end
				end
				adc_pkg::HOLD: begin
					if (trig_hit)
						trig_pend <= 1'b1;
					if (xfer)
						state <= adc_pkg::COLLECT;
				end
				default: state <= adc_pkg::COLLECT;
			endcase
		end
	end

	// output register, only loaded on launch.
	always_ff @(posedge clk) begin
		if (fire)
			data <= store_next;
	end

	a_hold_stable: assert property (@(posedge clk) disable iff (rst)
		(valid && !ready) |=> (valid && $stable(data)));

endmodule

// File: hw/adc_intf.sv
`timescale 1ns/10ps
`include "adc_macros.svh"

module adc_intf (
	input logic clk,
	input logic rst,
	input logic [`MEM_SIZE-1:0] fresh_bits,
	input logic [`MEM_SIZE-1:0][`WD_DATA_WIDTH-1:0] read_resps,
	output logic state_rdy,
	output logic sdc_valid,
	output logic [`SDC_SAMPLES-1:0][`WD_DATA_WIDTH-1:0] sdc_data,
	input logic sdc_ready,
	output logic cmc_valid,
	output logic [`CHAN_SAMPLES-1:0][`WD_DATA_WIDTH-1:0] cmc_data,
	input logic cmc_ready,
	output logic buffc_valid,
	output logic [`WD_DATA_WIDTH-1:0] buffc_data,
	input logic buffc_ready
);
	// write bus shared by all gatherers.
	logic wr_en;
	logic [`ADDR_WIDTH-1:0] wr_addr;
	logic [`WD_DATA_WIDTH-1:0] wr_data;
	adc_pkg::region_t wr_region;

	mem_capture capture (
		.clk(clk),
		.rst(rst),
		.fresh_bits(fresh_bits),
		.read_resps(read_resps),
		.state_rdy(state_rdy),
		.wr_en(wr_en),
		.wr_addr(wr_addr),
		.wr_data(wr_data),
		.wr_region(wr_region)
	);

	packet_gather #(
		.SAMPLES(`SDC_SAMPLES),
		.BASE_ID(`SDC_BASE_ID),
		.VALID_ID(`SDC_VALID_ID),
		.REGION(adc_pkg::REGION_SDC)
	) sdc_gather (
		.clk(clk),
		.rst(rst),
		.wr_en(wr_en),
		.wr_addr(wr_addr),
		.wr_data(wr_data),
		.wr_region(wr_region),
		.valid(sdc_valid),
		.data(sdc_data),
		.ready(sdc_ready)
	);

	packet_gather #(
		.SAMPLES(`CHAN_SAMPLES),
		.BASE_ID(`CHAN_MUX_BASE_ID),
		.VALID_ID(`CHAN_MUX_VALID_ID),
		.REGION(adc_pkg::REGION_CHAN)
	) cmc_gather (
		.clk(clk),
		.rst(rst),
		.wr_en(wr_en),
		.wr_addr(wr_addr),
		.wr_data(wr_data),
		.wr_region(wr_region),
		.valid(cmc_valid),
		.data(cmc_data),
		.ready(cmc_ready)
	);

	// one word, its own address is the trigger.
	packet_gather #(
		.SAMPLES(1),
		.BASE_ID(`BUFF_CONFIG_ID),
		.VALID_ID(`BUFF_CONFIG_ID),
		.REGION(adc_pkg::REGION_BUFF)
	) buffc_gather (
		.clk(clk),
		.rst(rst),
		.wr_en(wr_en),
		.wr_addr(wr_addr),
		.wr_data(wr_data),
		.wr_region(wr_region),
		.valid(buffc_valid),
		.data(buffc_data),
		.ready(buffc_ready)
	);

endmodule

// File: dv/adc_checker.sv
`timescale 1ns/10ps
`include "adc_macros.svh"

module adc_checker (
	input logic clk,
	input logic rst,
	input logic [`MEM_SIZE-1:0] fresh_bits,
	input logic [`MEM_SIZE-1:0][`WD_DATA_WIDTH-1:0] read_resps,
	input logic state_rdy,
	input logic sdc_valid,
	input logic [`SDC_SAMPLES-1:0][`WD_DATA_WIDTH-1:0] sdc_data,
	input logic sdc_ready,
	input logic cmc_valid,
	input logic [`CHAN_SAMPLES-1:0][`WD_DATA_WIDTH-1:0] cmc_data,
	input logic cmc_ready,
	input logic buffc_valid,
	input logic [`WD_DATA_WIDTH-1:0] buffc_data,
	input logic buffc_ready
);
	int errors = 0;
	int test_errs = 0;
	int pass_cnt = 0;
	int fail_cnt = 0;
	int xfer_total = 0;
	logic [`WD_DATA_WIDTH-1:0] store [3][`SDC_SAMPLES];
	logic [`WD_DATA_WIDTH-1:0] expct [3][`SDC_SAMPLES]; // packet the model expects on the stream.
	adc_pkg::gather_state_t st [3];
	bit pend [3];
	int wq_addr [$]; // captured words, delivery order.
	logic [`WD_DATA_WIDTH-1:0] wq_data [$];
	bit skip;

	// gatherer 0 is sdc, 1 is cmc, 2 is buffc.
	function automatic int words_of(input int g);
		return (g == 0) ? `SDC_SAMPLES : (g == 1) ? `CHAN_SAMPLES : 1;
	endfunction

	function automatic int base_of(input int g);
		return (g == 0) ? `SDC_BASE_ID : (g == 1) ? `CHAN_MUX_BASE_ID : `BUFF_CONFIG_ID;
	endfunction

	function automatic int trig_of(input int g);
		return (g == 0) ? `SDC_VALID_ID : (g == 1) ? `CHAN_MUX_VALID_ID : `BUFF_CONFIG_ID;
	endfunction

	function automatic adc_pkg::region_t region_for(input int g);
		return (g == 0) ? adc_pkg::REGION_SDC : (g == 1) ? adc_pkg::REGION_CHAN :
			adc_pkg::REGION_BUFF;
	endfunction

	function automatic adc_pkg::region_t region_of(input int a);
		if (a >= `SDC_BASE_ID && a < `SDC_BASE_ID + `SDC_SAMPLES)
			return adc_pkg::REGION_SDC;
		if (a >= `CHAN_MUX_BASE_ID && a < `CHAN_MUX_BASE_ID + `CHAN_SAMPLES)
			return adc_pkg::REGION_CHAN;
		if (a == `BUFF_CONFIG_ID)
			return adc_pkg::REGION_BUFF;
		return adc_pkg::REGION_NONE;
	endfunction

	function automatic logic valid_of(input int g);
		return (g == 0) ? sdc_valid : (g == 1) ? cmc_valid : buffc_valid;
	endfunction

	function automatic logic ready_of(input int g);
		return (g == 0) ? sdc_ready : (g == 1) ? cmc_ready : buffc_ready;
	endfunction

	function automatic logic [`WD_DATA_WIDTH-1:0] dut_word(input int g, input int i);
		if (g == 0)
			return sdc_data[i % `SDC_SAMPLES];
		if (g == 1)
			return cmc_data[i % `CHAN_SAMPLES];
		return buffc_data;
	endfunction

	task automatic mismatch(input string msg);
		errors++;
		$display("FAILED %0t: %s", $time, msg);
	endtask

	task automatic end_test(input string name);
		if (errors == test_errs) begin
			pass_cnt++;
			$display("test %s passed", name);
		end else begin
			fail_cnt++;
			$display("test %s failed with %0d errors", name, errors - test_errs);
		end
		test_errs = errors;
	endtask

	task automatic summary();
		$display("tests passed: %0d, failed: %0d", pass_cnt, fail_cnt);
	endtask

	task automatic reset_model();
		for (int g = 0; g < 3; g++) begin
			st[g] = adc_pkg::COLLECT;
			pend[g] = 0;
			for (int i = 0; i < `SDC_SAMPLES; i++) begin
				store[g][i] = '0;
				expct[g][i] = '0;
			end
		end
		wq_addr.delete();
		wq_data.delete();
		skip = 0;
	endtask

	task automatic check_stream(input int g);
		bit hold;
		hold = (st[g] == adc_pkg::HOLD);
		if (valid_of(g) !== hold) begin
			mismatch($sformatf("gatherer %0d valid is %b, model state %s",
				g, valid_of(g), st[g].name()));
		end else if (hold) begin
			for (int i = 0; i < words_of(g); i++) begin
				if (dut_word(g, i) !== expct[g][i])
					mismatch($sformatf("gatherer %0d word %0d is %h, expected %h",
						g, i, dut_word(g, i), expct[g][i]));
			end
		end
	endtask

	// store, trigger and transfer rules for one gatherer at one edge.
	task automatic step_model(input int g, input bit have_w, input int a,
			input logic [`WD_DATA_WIDTH-1:0] d);
		bit trig;
		if (have_w && region_of(a) == region_for(g))
			store[g][a - base_of(g)] = d;
		trig = have_w && (a == trig_of(g));
		if (st[g] == adc_pkg::COLLECT) begin
			if (trig || pend[g]) begin
				for (int i = 0; i < `SDC_SAMPLES; i++)
					expct[g][i] = store[g][i];
				st[g] = adc_pkg::HOLD;
				pend[g] = 0;
			end
		end else begin
			if (trig)
				pend[g] = 1; // fires again after the transfer.
			if (ready_of(g))
				st[g] = adc_pkg::COLLECT;
		end
	endtask

	always @(posedge clk) begin
		int a;
		logic [`WD_DATA_WIDTH-1:0] d;
		bit have_w;
		have_w = 0;
		a = 0;
		d = '0;
		if (rst) begin
			reset_model();
		end else begin
			if (state_rdy !== (wq_addr.size() == 0))
				mismatch($sformatf("state_rdy is %b with %0d words pending",
					state_rdy, wq_addr.size()));
			for (int g = 0; g < 3; g++)
				check_stream(g);
			for (int g = 0; g < 3; g++) begin
				if (valid_of(g) && ready_of(g))
					xfer_total++; // transfers seen on the ports.
			end
			if (wq_addr.size() != 0) begin
				if (skip) begin
					skip = 0; // first pulse lags the capture by a cycle.
				end else begin
					a = wq_addr.pop_front();
					d = wq_data.pop_front();
					have_w = 1;
				end
			end
			for (int g = 0; g < 3; g++)
				step_model(g, have_w, a, d);
			if (state_rdy && |fresh_bits) begin
				for (int i = 0; i < `MEM_SIZE; i++) begin
					if (fresh_bits[i]) begin
						wq_addr.push_back(i);
						wq_data.push_back(read_resps[i]);
					end
				end
				skip = 1;
			end
		end
	end

endmodule

// File: dv/adc_intf_tb.sv
`timescale 1ns/10ps
`include "adc_macros.svh"

module adc_intf_tb;
	localparam int TIMEOUT = 400;

	logic clk = 1'b0;
	logic rst;
	logic [`MEM_SIZE-1:0] fresh_bits;
	logic [`MEM_SIZE-1:0][`WD_DATA_WIDTH-1:0] read_resps;
	logic state_rdy;
	logic sdc_valid, sdc_ready;
	logic [`SDC_SAMPLES-1:0][`WD_DATA_WIDTH-1:0] sdc_data;
	logic cmc_valid, cmc_ready;
	logic [`CHAN_SAMPLES-1:0][`WD_DATA_WIDTH-1:0] cmc_data;
	logic buffc_valid, buffc_ready;
	logic [`WD_DATA_WIDTH-1:0] buffc_data;
	logic [`WD_DATA_WIDTH-1:0] mem [`MEM_SIZE]; // host copy of the memory map.
	bit rand_ready = 0;
	int xfers_before;

	always #20 clk = ~clk;

	adc_intf uut (
		.clk(clk), .rst(rst), .fresh_bits(fresh_bits), .read_resps(read_resps),
		.state_rdy(state_rdy),
		.sdc_valid(sdc_valid), .sdc_data(sdc_data), .sdc_ready(sdc_ready),
		.cmc_valid(cmc_valid), .cmc_data(cmc_data), .cmc_ready(cmc_ready),
		.buffc_valid(buffc_valid), .buffc_data(buffc_data), .buffc_ready(buffc_ready)
	);

	adc_checker chk (
		.clk(clk), .rst(rst), .fresh_bits(fresh_bits), .read_resps(read_resps),
		.state_rdy(state_rdy),
		.sdc_valid(sdc_valid), .sdc_data(sdc_data), .sdc_ready(sdc_ready),
		.cmc_valid(cmc_valid), .cmc_data(cmc_data), .cmc_ready(cmc_ready),
		.buffc_valid(buffc_valid), .buffc_data(buffc_data), .buffc_ready(buffc_ready)
	);

	// random back-pressure.
	always @(posedge clk) begin
		#2;
		if (rand_ready) begin
			sdc_ready = 1'($urandom % 2);
			cmc_ready = 1'($urandom % 2);
			buffc_ready = 1'($urandom % 2);
		end
	end

	task automatic abort_on_timeout(input string what);
		$display("timeout while waiting for %s", what);
		$display("Regression failed");
		$finish;
	endtask

	task automatic set_ready(input logic r);
		sdc_ready = r;
		cmc_ready = r;
		buffc_ready = r;
	endtask

	task automatic stage_word(input int addr, input logic [`WD_DATA_WIDTH-1:0] d);
		mem[addr] = d;
		read_resps[addr] = mem[addr];
		fresh_bits[addr] = 1'b1;
	endtask

	// hold the staged words until a capture edge takes them.
	task automatic commit_words();
		int n;
		n = 0;
		do begin
			@(posedge clk);
			n++;
			if (n > TIMEOUT)
				abort_on_timeout("state_rdy");
		end while (!state_rdy);
		#2;
		fresh_bits = '0;
	endtask

	task automatic wait_transfer(input int g);
		int n;
		bit hit;
		n = 0;
		do begin
			@(posedge clk);
			n++;
			if (n > TIMEOUT)
				abort_on_timeout($sformatf("a transfer on stream %0d", g));
			hit = (g == 0) ? (sdc_valid && sdc_ready) :
				(g == 1) ? (cmc_valid && cmc_ready) : (buffc_valid && buffc_ready);
		end while (!hit);
		#2;
	endtask

	task automatic wait_sdc_valid();
		int n;
		n = 0;
		do begin
			@(posedge clk);
			n++;
			if (n > TIMEOUT)
				abort_on_timeout("sdc_valid");
		end while (!sdc_valid);
		#2;
	endtask

	// idle means no word in flight and no stream valid for a few edges.
	task automatic wait_idle();
		int n;
		int quiet;
		n = 0;
		quiet = 0;
		while (quiet < 4) begin
			@(posedge clk);
			n++;
			if (n > TIMEOUT)
				abort_on_timeout("the interface to go idle");
			if (state_rdy && !sdc_valid && !cmc_valid && !buffc_valid)
				quiet++;
			else
				quiet = 0;
		end
		#2;
	endtask

	initial begin
		bit [`MEM_SIZE-1:0] used;
		int n_words;
		int a;
		void'($urandom(32'h72fa_05e0));
		rst = 1'b1;
		fresh_bits = '0;
		read_resps = '0;
		set_ready(1'b0);
		repeat (3) @(posedge clk);
		#2;
		rst = 1'b0;

		@(posedge clk);
		#2;
		if (sdc_valid || cmc_valid || buffc_valid || !state_rdy)
			chk.mismatch("outputs not idle after reset");
		chk.end_test("reset");

		set_ready(1'b1);
		for (int i = 0; i < `SDC_SAMPLES; i++)
			stage_word(`SDC_BASE_ID + i, 8'($urandom));
		stage_word(`SDC_VALID_ID, 8'($urandom)); // highest address, goes out last.
		commit_words();
		wait_transfer(0);
		chk.end_test("sdc packet");

		for (int i = 0; i < `CHAN_SAMPLES; i++)
			stage_word(`CHAN_MUX_BASE_ID + i, 8'($urandom));
		stage_word(`CHAN_MUX_VALID_ID, 8'($urandom));
		commit_words();
		wait_transfer(1);
		chk.end_test("cmc packet");

		stage_word(`BUFF_CONFIG_ID, 8'($urandom));
		commit_words();
		wait_transfer(2);
		chk.end_test("buffc packet");

		set_ready(1'b0);
		for (int i = 0; i < `SDC_SAMPLES; i++)
			stage_word(`SDC_BASE_ID + i, 8'($urandom));
		stage_word(`SDC_VALID_ID, 8'($urandom));
		commit_words();
		wait_sdc_valid();
		for (int i = 0; i < `SDC_SAMPLES; i++)
			stage_word(`SDC_BASE_ID + i, 8'($urandom)); // new samples, no trigger.
		commit_words();
		repeat (12) @(posedge clk);
		#2;
		sdc_ready = 1'b1;
		wait_transfer(0);
		stage_word(`SDC_VALID_ID, 8'($urandom));
		commit_words();
		wait_transfer(0);
		chk.end_test("back-pressure");

		@(negedge clk);
		rand_ready = 1;
		@(posedge clk);
		#2;
		for (int b = 0; b < 24; b++) begin
			used = '0;
			n_words = 1 + int'($urandom % 6);
			for (int k = 0; k < n_words; k++) begin
				a = int'($urandom % 16);
				if (!used[a]) begin
					used[a] = 1'b1;
					stage_word(a, 8'($urandom));
				end
			end
			commit_words();
		end
		@(negedge clk);
		rand_ready = 0;
		@(posedge clk);
		#2;
		set_ready(1'b1);
		wait_idle();
		chk.end_test("random interleaved");

		xfers_before = chk.xfer_total;
		for (int b = 0; b < 4; b++) begin
			stage_word(15 + int'($urandom % 17), 8'($urandom));
			stage_word(15 + int'($urandom % 17), 8'($urandom));
			commit_words();
		end
		wait_idle();
		if (chk.xfer_total != xfers_before)
			chk.mismatch("writes to unused addresses caused a transfer");
		chk.end_test("unused addresses");

		chk.summary();
		if (chk.fail_cnt == 0 && chk.errors == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

// File: src.f
+incdir+common
common/adc_pkg.sv
hw/mem_capture.sv
hw/packet_gather.sv
hw/adc_intf.sv
dv/adc_checker.sv
dv/adc_intf_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= adc_intf_tb
OBJ_DIR ?= obj_dir
FILELIST ?= src.f
VFLAGS ?= --binary --timing --assert -j 0 -Wno-fatal
PASS_MSG ?= Regression passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^$(PASS_MSG)$$"

clean:
	rm -rf $(OBJ_DIR)
